// File: build.f
+incdir+include
design/jtag_slave_pkg.sv
design/word_fifo.sv
design/bus_write_channel.sv
design/bus_read_channel.sv
design/jtag_status_reg.sv
design/jtag_shift_engine.sv
design/jtag_slave_top.sv
tb/tb_jtag_slave.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       ?= tb_jtag_slave
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the trace testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "Result: PASSED"

clean:
	rm -rf $(OBJ_DIR)

// File: tb/jtag_slave_trace.txt
# w id addr burst beats strb data.. resp | r id addr burst len (data resp)..
# p polls status until done | m 0 fixed ready, m 1 random ready
m 0
r 1 10000000 0 0 01020202 0
# loopback shift of 8, 32 and 5 bits
w 2 10000002 0 3 f a5a5a5a5 12345678 deadbeef 0
w 3 10000003 0 3 f 10000008 10000020 10000005 0
p
r 4 10000001 0 2 000000a5 0 12345678 0 0000000f 0
# error responses
w 5 10000001 0 1 f 11111111 2
w 6 10000005 0 1 f 22222222 2
w 7 10000002 2 1 f 33333333 2
r 8 10000002 0 0 ffffffff 2
r 9 10000003 0 0 ffffffff 2
# INCR write of data then SHIFT 16, INCR read runs off the map
w a 10000002 1 2 f cafef00d 10000010 0
p
r b 10000000 1 2 01020200 0 0000f00d 0 ffffffff 2
# data FIFO flush, byte 0 strobe alone must not flush
w c 10000002 0 2 f 0badf00d 87654321 0
r d 10000000 0 0 01020002 0
w d 10000000 0 1 1 00000100 0
r e 10000000 0 0 01020002 0
w e 10000000 0 1 2 00000100 0
r f 10000000 0 0 01020202 0
# shift-out FIFO flush
w 1 10000002 0 1 f 5a5a5a5a 0
w 2 10000003 0 1 f 10000020 0
p
r 3 10000000 0 0 01020200 0
w 4 10000000 0 1 1 00000001 0
r 5 10000000 0 0 01020202 0
# TMS_HIGH leaves the data word in place
w 6 10000002 0 1 f 0000abcd 0
w 7 10000003 0 1 f 20000006 0
p
r 8 10000000 0 0 01020002 0
# random ready from here on
m 1
w 9 10000003 0 1 f 10000010 0
p
r a 10000001 0 0 0000abcd 0
w b 10000002 0 2 f 13579bdf 0f0f0f0f 0
w c 10000003 0 2 f 10000004 10000018 0
p
r d 10000001 0 1 0000000f 0 000f0f0f 0
w e 10000005 1 2 f 00000001 00000002 2
r f 10000002 1 1 ffffffff 2 ffffffff 2
r 1 10000000 0 0 01020202 0

// File: tb/tb_jtag_slave.sv
`timescale 1ns/1ns
`include "jtag_slave_cfg.svh"

module tb_jtag_slave;
    import jtag_slave_pkg::*;

    localparam logic [31:0] cmd_addr = `JTAG_BASE_ADDR + `JTAG_REG_SHIFT_CMD;

    logic        clk;
    logic        jtag_rstn_sync;
    bus_addr_t   aw, ar;
    bus_wdata_t  w;
    bus_bresp_t  b;
    bus_rdata_t  r;
    logic        aw_valid, aw_ready, w_valid, w_ready, b_valid;
    logic        ar_valid, ar_ready, r_valid;
    logic        b_ready = 1'b0;
    logic        r_ready = 1'b0;
    logic        tck, tms, tdi, tdo;

    integer      seed = 32'h393f66f4;
    integer      err_count = 0;
    integer      check_count = 0;
    integer      watchdog_cycles = 0;
    integer      tck_shift_rises = 0;             // tck rising edges with tms low
    integer      tck_tms_rises = 0;               // tck rising edges with tms high
    integer      exp_shift_rises = 0;
    integer      exp_tms_rises = 0;
    logic        random_ready = 1'b0;
    logic [31:0] last_rdata;
    logic [31:0] words[$];                        // beat data for the current trace entry
    logic [1:0]  resps[$];

    assign tdo = tdi;                             // loopback, captured bits equal shifted bits

    jtag_slave_top dut (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        logic [31:0] rnd_b, rnd_r;
        rnd_b = $random(seed);
        rnd_r = $random(seed);
        b_ready <= random_ready ? rnd_b[0] : 1'b1;
        r_ready <= random_ready ? rnd_r[0] : 1'b1;
    end

    always @(posedge tck) begin
        if (tms)
            tck_tms_rises++;
        else
            tck_shift_rises++;
    end

    task automatic compare_field(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        check_count++;
        assert (got === exp)
            else begin
                err_count++;
                $display("CHECK FAILED: %s = %h, expected %h at %0t", name, got, exp, $time);
            end
    endtask

    // tck cycles a command word asks for, by opcode
    task automatic count_cmd_rises(input logic [31:0] cmd);
        logic [3:0]  opc;
        logic [27:0] n;
        opc = cmd[31:28];
        n   = cmd[27:0];
        if (opc == OP_SHIFT && n >= 28'd1 && n <= `JTAG_MAX_SHIFT)
            exp_shift_rises += int'(n);
        else if (opc == OP_TMS_HIGH)
            exp_tms_rises += int'(n);
    endtask

    task automatic send_write(input logic [3:0] a_id, input logic [31:0] a_addr,
                              input logic [1:0] a_burst, input logic [3:0] a_strb,
                              input logic [1:0] exp_resp);
        int n;
        n = words.size();
        @(posedge clk);
        aw_valid <= 1'b1;
        aw       <= '{id: a_id, addr: a_addr, len: 8'(n - 1), burst: a_burst};
        @(negedge clk);
        while (!aw_ready) @(negedge clk);
        @(posedge clk);                           // aw transfer
        aw_valid <= 1'b0;
        for (int i = 0; i < n; i++) begin
            w_valid <= 1'b1;
            w       <= '{data: words[i], strb: a_strb, last: (i == n - 1)};
            @(negedge clk);
            while (!w_ready) @(negedge clk);
            @(posedge clk);
        end
        w_valid <= 1'b0;
        @(negedge clk);
        while (!(b_valid && b_ready)) @(negedge clk);
        compare_field("b.id", 32'(b.id), 32'(a_id));
        compare_field("b.resp", 32'(b.resp), 32'(exp_resp));
        @(posedge clk);
    endtask

    task automatic send_read(input logic [3:0] a_id, input logic [31:0] a_addr,
                             input logic [1:0] a_burst, input logic [7:0] a_len,
                             input bit check_data);
        @(posedge clk);
        ar_valid <= 1'b1;
        ar       <= '{id: a_id, addr: a_addr, len: a_len, burst: a_burst};
        @(negedge clk);
        while (!ar_ready) @(negedge clk);
        @(posedge clk);
        ar_valid <= 1'b0;
        for (int i = 0; i <= int'(a_len); i++) begin
            @(negedge clk);
            while (!(r_valid && r_ready)) @(negedge clk);
            last_rdata = r.data;
            compare_field("r.id", 32'(r.id), 32'(a_id));
            compare_field("r.last", 32'(r.last), 32'(i == int'(a_len)));
            if (check_data) begin
                compare_field("r.data", r.data, words[i]);
                compare_field("r.resp", 32'(r.resp), 32'(resps[i]));
            end
            @(posedge clk);
        end
    endtask

    // status reads until the engine has drained the command FIFO
    task automatic poll_done;
        status_word_t st;
        st = '0;
        while (!st.done) begin
            send_read(4'h0, `JTAG_BASE_ADDR + `JTAG_REG_STATUS, BURST_FIXED, 8'd0, 1'b0);
            st = last_rdata;
        end
    endtask

    initial begin
        integer        fd, code, lines;
        logic [1023:0] line;
        logic [7:0]    op;
        logic [3:0]    f_id, f_strb;
        logic [31:0]   f_addr, f_word, f_val;
        logic [1:0]    f_burst, f_resp;
        logic [7:0]    f_cnt;
        jtag_rstn_sync = 1'b0;
        aw = '0;
        ar = '0;
        w = '0;
        aw_valid = 1'b0;
        w_valid = 1'b0;
        ar_valid = 1'b0;
        lines = 0;
        fd = $fopen("tb/jtag_slave_trace.txt", "r");
        if (fd == 0) begin
            $display("could not open the trace file tb/jtag_slave_trace.txt");
            err_count++;
        end else begin
            while (!$feof(fd)) begin
                code = $fgets(line, fd);
                if (code != 0)
                    lines++;
            end
            $fclose(fd);
            watchdog_cycles = lines * 400;
            repeat (3) @(posedge clk);
            jtag_rstn_sync <= 1'b1;
            fd = $fopen("tb/jtag_slave_trace.txt", "r");
            while ($fscanf(fd, " %s", op) == 1) begin
                words.delete();
                resps.delete();
                case (op)
                    "#": code = $fgets(line, fd);
                    "m": begin
                        code = $fscanf(fd, " %h", f_val);
                        random_ready = (f_val != 0);
                    end
                    "p": poll_done();
                    "w": begin
                        code = $fscanf(fd, " %h %h %h %h %h", f_id, f_addr, f_burst,
                                       f_cnt, f_strb);
                        for (int k = 0; k < int'(f_cnt); k++) begin
                            code = $fscanf(fd, " %h", f_word);
                            words.push_back(f_word);
                            if ((f_burst == BURST_FIXED && f_addr == cmd_addr) ||
                                (f_burst == BURST_INCR && f_addr + k == cmd_addr))
                                count_cmd_rises(f_word);
                        end
                        code = $fscanf(fd, " %h", f_resp);
                        send_write(f_id, f_addr, f_burst, f_strb, f_resp);
                    end
                    "r": begin
                        code = $fscanf(fd, " %h %h %h %h", f_id, f_addr, f_burst, f_cnt);
                        for (int k = 0; k <= int'(f_cnt); k++) begin
                            code = $fscanf(fd, " %h %h", f_word, f_resp);
                            words.push_back(f_word);
                            resps.push_back(f_resp);
                        end
                        send_read(f_id, f_addr, f_burst, f_cnt, 1'b1);
                    end
                    default: begin
                        $display("unknown entry '%s' in the trace file", op);
                        err_count++;
                    end
                endcase
            end
            $fclose(fd);
            compare_field("tck_shift_rises", 32'(tck_shift_rises), 32'(exp_shift_rises));
            compare_field("tck_tms_rises", 32'(tck_tms_rises), 32'(exp_tms_rises));
            compare_field("tck", 32'(tck), 32'd0);        // parked low when idle
            compare_field("tms", 32'(tms), 32'd1);
        end
        $display("checks: %0d  errors: %0d", check_count, err_count);
        if (err_count == 0 && check_count > 0)
            $display("Result: PASSED");
        else
            $display("Result: FAILED");
        $finish;
    end

    initial begin
        wait (watchdog_cycles > 0);
        repeat (watchdog_cycles) @(posedge clk);
        $display("timeout: the trace did not finish within %0d cycles", watchdog_cycles);
        $display("Result: FAILED");
        $finish;
    end

endmodule

// File: design/jtag_slave_top.sv
`timescale 1ns/1ns
`include "jtag_slave_cfg.svh"

module jtag_slave_top (
    input  logic                       clk,
    input  logic                       jtag_rstn_sync,
    input  jtag_slave_pkg::bus_addr_t  aw,
    input  logic                       aw_valid,
    output logic                       aw_ready,
    input  jtag_slave_pkg::bus_wdata_t w,
    input  logic                       w_valid,
    output logic                       w_ready,
    output jtag_slave_pkg::bus_bresp_t b,
    output logic                       b_valid,
    input  logic                       b_ready,
    input  jtag_slave_pkg::bus_addr_t  ar,
    input  logic                       ar_valid,
    output logic                       ar_ready,
    output jtag_slave_pkg::bus_rdata_t r,
    output logic                       r_valid,
    input  logic                       r_ready,
    output logic                       tck,
    output logic                       tms,
    output logic                       tdi,
    input  logic                       tdo
);
    import jtag_slave_pkg::*;

    bus_wdata_t              wdata;
    status_word_t            status_rd;
    logic                    status_we, data_push, cmd_push, out_push;
    logic                    data_pop, cmd_pop, out_pop;
    logic                    out_flush, data_flush, cmd_flush;
    logic [`JTAG_DATA_W-1:0] data_head, cmd_head, out_head, out_word;
    logic                    data_not_empty, cmd_not_empty, out_not_empty;
    logic                    data_full, cmd_full, out_full;
    logic                    engine_idle;

    bus_write_channel u_wr (
        .clk(clk), .jtag_rstn_sync(jtag_rstn_sync),
        .aw(aw), .aw_valid(aw_valid), .aw_ready(aw_ready),
        .w(w), .w_valid(w_valid), .w_ready(w_ready),
        .b(b), .b_valid(b_valid), .b_ready(b_ready),
        .data_full(data_full), .cmd_full(cmd_full),
        .status_we(status_we), .data_push(data_push), .cmd_push(cmd_push),
        .wdata(wdata)
    );

    bus_read_channel u_rd (
        .clk(clk), .jtag_rstn_sync(jtag_rstn_sync),
        .ar(ar), .ar_valid(ar_valid), .ar_ready(ar_ready),
        .r(r), .r_valid(r_valid), .r_ready(r_ready),
        .status_rd(status_rd), .out_head(out_head),
        .out_not_empty(out_not_empty), .out_pop(out_pop)
    );

    jtag_status_reg u_status (
        .clk(clk), .jtag_rstn_sync(jtag_rstn_sync),
        .status_we(status_we), .wdata(wdata),
        .out_not_empty(out_not_empty), .out_full(out_full),
        .data_not_empty(data_not_empty), .data_full(data_full),
        .cmd_not_empty(cmd_not_empty), .cmd_full(cmd_full),
        .engine_idle(engine_idle), .status_rd(status_rd),
        .out_flush(out_flush), .data_flush(data_flush), .cmd_flush(cmd_flush)
    );

    word_fifo #(.DEPTH_LOG2(`JTAG_FIFO_DEPTH_LOG2)) u_data_fifo (
        .clk(clk), .jtag_rstn_sync(jtag_rstn_sync), .flush(data_flush),
        .push(data_push), .push_data(wdata.data), .pop(data_pop),
        .head(data_head), .not_empty(data_not_empty), .full(data_full)
    );

    word_fifo #(.DEPTH_LOG2(`JTAG_FIFO_DEPTH_LOG2)) u_cmd_fifo (
        .clk(clk), .jtag_rstn_sync(jtag_rstn_sync), .flush(cmd_flush),
        .push(cmd_push), .push_data(wdata.data), .pop(cmd_pop),
        .head(cmd_head), .not_empty(cmd_not_empty), .full(cmd_full)
    );

    word_fifo #(.DEPTH_LOG2(`JTAG_FIFO_DEPTH_LOG2)) u_out_fifo (
        .clk(clk), .jtag_rstn_sync(jtag_rstn_sync), .flush(out_flush),
        .push(out_push), .push_data(out_word), .pop(out_pop),
        .head(out_head), .not_empty(out_not_empty), .full(out_full)
    );

    jtag_shift_engine u_engine (
        .clk(clk), .jtag_rstn_sync(jtag_rstn_sync),
        .cmd_word(cmd_head), .cmd_not_empty(cmd_not_empty), .cmd_pop(cmd_pop),
        .data_word(data_head), .data_not_empty(data_not_empty), .data_pop(data_pop),
        .out_full(out_full), .out_push(out_push), .out_word(out_word),
        .tck(tck), .tms(tms), .tdi(tdi), .tdo(tdo), .idle(engine_idle)
    );

endmodule

// File: design/jtag_shift_engine.sv
`timescale 1ns/1ns
`include "jtag_slave_cfg.svh"

module jtag_shift_engine (
    input  logic                    clk,
    input  logic                    jtag_rstn_sync,
    input  logic [`JTAG_DATA_W-1:0] cmd_word,
    input  logic                    cmd_not_empty,
    input  logic [`JTAG_DATA_W-1:0] data_word,
    input  logic                    data_not_empty,
    input  logic                    out_full,
    input  logic                    tdo,
    output logic                    cmd_pop,
    output logic                    data_pop,
    output logic                    out_push,
    output logic [`JTAG_DATA_W-1:0] out_word,
    output logic                    tck,
    output logic                    tms,
    output logic                    tdi,
    output logic                    idle
);
    import jtag_slave_pkg::*;

    typedef enum logic [1:0] {E_IDLE, E_LOAD, E_RUN, E_PUSH} eng_state_e;

    eng_state_e              state;
    jtag_word_u              cmd_u;
    logic                    is_shift, shift_ok, half_tick;
    logic                    shift_q;                   // running command is a SHIFT
    logic [27:0]             cnt_q;                     // tck cycles still to go
    logic [5:0]              nbits_q;
    logic [`JTAG_DATA_W-1:0] sh_in_q, cap_q;
    logic [7:0]              div_q;

    assign cmd_u     = cmd_word;
    assign is_shift  = (cmd_u.cmd.opcode == OP_SHIFT);
    assign shift_ok  = (cmd_u.cmd.cycle_num != '0) && (cmd_u.cmd.cycle_num <= `JTAG_MAX_SHIFT);
    assign half_tick = (div_q == 8'(`JTAG_TCK_HALF - 1));

    assign idle     = (state == E_IDLE);
    assign cmd_pop  = idle && cmd_not_empty;
    assign data_pop = (state == E_LOAD) && data_not_empty;
    assign out_push = (state == E_PUSH) && !out_full;
    assign out_word = cap_q >> (`JTAG_MAX_SHIFT - nbits_q);  // captured bits to the bottom

    always_ff @(posedge clk or negedge jtag_rstn_sync) begin
        if (!jtag_rstn_sync) begin
            state   <= E_IDLE;
            tck     <= 1'b0;
            tms     <= 1'b1;
            tdi     <= 1'b0;
            div_q   <= '0;
            cnt_q   <= '0;
            shift_q <= 1'b0;
        end else begin
            case (state)
                E_IDLE: if (cmd_pop) begin
                    shift_q <= is_shift;
                    cnt_q   <= cmd_u.cmd.cycle_num;
                    div_q   <= '0;
                    if (is_shift && shift_ok) begin
                        tms   <= 1'b0;
                        state <= E_LOAD;
                    end else if (cmd_u.cmd.opcode == OP_TMS_HIGH &&
                                 cmd_u.cmd.cycle_num != '0) begin
                        state <= E_RUN;         // tms already high
                    end
                end
                E_LOAD: if (data_pop) begin     // tck parked low until data arrives
                    tdi   <= data_word[0];
                    state <= E_RUN;
                end
                E_RUN: begin
                    div_q <= half_tick ? '0 : div_q + 1'b1;
                    if (half_tick) begin
                        tck <= !tck;
                        if (!tck) begin
                            cnt_q <= cnt_q - 1'b1;
                        end else begin
                            if (shift_q)
                                tdi <= sh_in_q[1];  // next bit on the falling edge
                            if (cnt_q == '0) begin
                                tms   <= 1'b1;
                                state <= shift_q ? E_PUSH : E_IDLE;
                            end
                        end
                    end
                end
                E_PUSH: if (out_push) state <= E_IDLE;
                default: state <= E_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (cmd_pop)
            nbits_q <= cmd_u.cmd.cycle_num[5:0];
        if (data_pop) begin
            sh_in_q <= data_word;
        end else if (state == E_RUN && half_tick) begin
            if (!tck)
                cap_q <= {tdo, cap_q[`JTAG_DATA_W-1:1]};  // sample at rising tck
            else
                sh_in_q <= sh_in_q >> 1;
        end
    end

    a_shift_len: assert property (@(posedge clk) disable iff (!jtag_rstn_sync)
        (cmd_pop && is_shift) |-> shift_ok)
        else $error("SHIFT command with a bit count outside 1..32");

endmodule

// File: design/jtag_status_reg.sv
`timescale 1ns/1ns

module jtag_status_reg (
    input  logic                         clk,
    input  logic                         jtag_rstn_sync,
    input  logic                         status_we,
    input  jtag_slave_pkg::bus_wdata_t   wdata,
    input  logic                         out_not_empty,
    input  logic                         out_full,
    input  logic                         data_not_empty,
    input  logic                         data_full,
    input  logic                         cmd_not_empty,
    input  logic                         cmd_full,
    input  logic                         engine_idle,
    output jtag_slave_pkg::status_word_t status_rd,
    output logic                         out_flush,
    output logic                         data_flush,
    output logic                         cmd_flush
);
    import jtag_slave_pkg::*;

    jtag_word_u wr_word;

    assign wr_word = wdata.data;

    // flush bits drop back to zero on any cycle without a write
    always_ff @(posedge clk or negedge jtag_rstn_sync) begin
        if (!jtag_rstn_sync) begin
            out_flush  <= 1'b0;
            data_flush <= 1'b0;
            cmd_flush  <= 1'b0;
        end else begin
            out_flush  <= status_we && wdata.strb[0] && wr_word.status.out_flush;
            data_flush <= status_we && wdata.strb[1] && wr_word.status.data_flush;
            cmd_flush  <= status_we && wdata.strb[2] && wr_word.status.cmd_flush;
        end
    end

    always_comb begin
        status_rd            = '0;
        status_rd.out_flush  = out_flush;
        status_rd.out_empty  = !out_not_empty;
        status_rd.out_full   = out_full;
        status_rd.data_flush = data_flush;
        status_rd.data_empty = !data_not_empty;
        status_rd.data_full  = data_full;
        status_rd.cmd_flush  = cmd_flush;
        status_rd.cmd_empty  = !cmd_not_empty;
        status_rd.cmd_full   = cmd_full;
        status_rd.done       = engine_idle && !cmd_not_empty;  // nothing left to run
    end

endmodule

// File: design/bus_read_channel.sv
`timescale 1ns/1ns
`include "jtag_slave_cfg.svh"

module bus_read_channel (
    input  logic                         clk,
    input  logic                         jtag_rstn_sync,
    input  jtag_slave_pkg::bus_addr_t    ar,
    input  logic                         ar_valid,
    output logic                         ar_ready,
    output jtag_slave_pkg::bus_rdata_t   r,
    output logic                         r_valid,
    input  logic                         r_ready,
    input  jtag_slave_pkg::status_word_t status_rd,
    input  logic [`JTAG_DATA_W-1:0]      out_head,
    input  logic                         out_not_empty,
    output logic                         out_pop
);
    import jtag_slave_pkg::*;

    typedef enum logic {RD_IDLE, RD_DATA} rd_state_e;

    rd_state_e               state, state_nxt;
    logic [`JTAG_ID_W-1:0]   id_q;
    logic [1:0]              burst_q;
    logic [`JTAG_LEN_W-1:0]  len_q;
    logic [`JTAG_LEN_W-1:0]  beat_q;
    logic [`JTAG_DATA_W-1:0] offset_q;
    logic                    err_q;
    logic                    bad;
    logic                    ar_fire, r_fire;

    assign ar_fire = ar_valid && ar_ready;
    assign r_fire  = r_valid && r_ready;

    // only status and shift-out are readable
    assign bad = err_q || (burst_q != BURST_FIXED && burst_q != BURST_INCR) ||
                 (offset_q > `JTAG_REG_SHIFT_OUT);

    always_comb begin
        state_nxt = state;
        case (state)
            RD_IDLE: if (ar_fire) state_nxt = RD_DATA;
            RD_DATA: if (r_fire && r.last) state_nxt = RD_IDLE;
            default: state_nxt = RD_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge jtag_rstn_sync) begin
        if (!jtag_rstn_sync) begin
            state    <= RD_IDLE;
            ar_ready <= 1'b0;
            beat_q   <= '0;
            err_q    <= 1'b0;
        end else begin
            state    <= state_nxt;
            ar_ready <= (state_nxt == RD_IDLE);
            if (ar_fire) begin
                beat_q <= '0;
                err_q  <= 1'b0;
            end else if (r_fire) begin
                beat_q <= beat_q + 1'b1;
                err_q  <= bad;                  // sticky for the rest of the burst
            end
        end
    end

    always_ff @(posedge clk) begin
        if (ar_fire) begin
            id_q     <= ar.id;
            burst_q  <= ar.burst;
            len_q    <= ar.len;
            offset_q <= ar.addr - `JTAG_BASE_ADDR;
        end else if (r_fire && burst_q == BURST_INCR) begin
            offset_q <= offset_q + 1'b1;
        end
    end

    // shift-out beats wait for data
    assign r_valid = (state == RD_DATA) &&
                     (bad || offset_q == `JTAG_REG_STATUS || out_not_empty);
    assign out_pop = r_fire && !bad && offset_q == `JTAG_REG_SHIFT_OUT;

    assign r.id   = id_q;
    assign r.last = (beat_q == len_q);
    assign r.resp = bad ? RESP_SLVERR : RESP_OKAY;
    assign r.data = bad ? '1 :
                    (offset_q == `JTAG_REG_STATUS) ? status_rd : out_head;

    a_pop_has_data: assert property (@(posedge clk) disable iff (!jtag_rstn_sync)
        out_pop |-> out_not_empty)
        else $error("shift-out FIFO popped while empty");

endmodule

// File: design/bus_write_channel.sv
`timescale 1ns/1ns
`include "jtag_slave_cfg.svh"

module bus_write_channel (
    input  logic                       clk,
    input  logic                       jtag_rstn_sync,
    input  jtag_slave_pkg::bus_addr_t  aw,
    input  logic                       aw_valid,
    output logic                       aw_ready,
    input  jtag_slave_pkg::bus_wdata_t w,
    input  logic                       w_valid,
    output logic                       w_ready,
    output jtag_slave_pkg::bus_bresp_t b,
    output logic                       b_valid,
    input  logic                       b_ready,
    input  logic                       data_full,
    input  logic                       cmd_full,
    output logic                       status_we,
    output logic                       data_push,
    output logic                       cmd_push,
    output jtag_slave_pkg::bus_wdata_t wdata
);
    import jtag_slave_pkg::*;

    typedef enum logic [1:0] {WR_IDLE, WR_DATA, WR_RESP} wr_state_e;

    wr_state_e               state, state_nxt;
    logic [`JTAG_ID_W-1:0]   id_q;
    logic [1:0]              burst_q;
    logic [`JTAG_DATA_W-1:0] offset_q;
    logic                    err_q;
    logic                    beat_err;
    logic                    aw_fire, w_fire;

    assign aw_fire = aw_valid && aw_ready;
    assign w_fire  = w_valid && w_ready;

    // bad burst type, outside the map, or the read-only shift-out port
    assign beat_err = (burst_q != BURST_FIXED && burst_q != BURST_INCR) ||
                      (offset_q > `JTAG_REG_SHIFT_CMD) ||
                      (offset_q == `JTAG_REG_SHIFT_OUT);

    always_comb begin
        state_nxt = state;
        case (state)
            WR_IDLE: if (aw_fire) state_nxt = WR_DATA;
            WR_DATA: if (w_fire && w.last) state_nxt = WR_RESP;
            WR_RESP: if (b_valid && b_ready) state_nxt = WR_IDLE;
            default: state_nxt = WR_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge jtag_rstn_sync) begin
        if (!jtag_rstn_sync) begin
            state    <= WR_IDLE;
            aw_ready <= 1'b0;
            err_q    <= 1'b0;
        end else begin
            state    <= state_nxt;
            aw_ready <= (state_nxt == WR_IDLE);
            if (aw_fire)
                err_q <= 1'b0;
            else if (w_fire && beat_err)
                err_q <= 1'b1;                  // held until the next burst
        end
    end

    always_ff @(posedge clk) begin
        if (aw_fire) begin
            id_q     <= aw.id;
            burst_q  <= aw.burst;
            offset_q <= aw.addr - `JTAG_BASE_ADDR;
        end else if (w_fire && burst_q == BURST_INCR) begin
            offset_q <= offset_q + 1'b1;
        end
    end

    always_comb begin
        w_ready = 1'b0;
        if (state == WR_DATA) begin
            if (beat_err || offset_q == `JTAG_REG_STATUS)
                w_ready = 1'b1;                 // error beats are dropped
            else if (offset_q == `JTAG_REG_SHIFT_IN)
                w_ready = !data_full;
            else
                w_ready = !cmd_full;
        end
    end

    assign status_we = w_fire && !beat_err && offset_q == `JTAG_REG_STATUS;
    assign data_push = w_fire && !beat_err && offset_q == `JTAG_REG_SHIFT_IN;
    assign cmd_push  = w_fire && !beat_err && offset_q == `JTAG_REG_SHIFT_CMD;
    assign wdata     = w;

    assign b_valid = (state == WR_RESP);
    assign b.id    = id_q;
    assign b.resp  = err_q ? RESP_SLVERR : RESP_OKAY;

    a_no_push_full: assert property (@(posedge clk) disable iff (!jtag_rstn_sync)
        !(data_push && data_full) && !(cmd_push && cmd_full))
        else $error("push into a full FIFO");

endmodule

// File: design/word_fifo.sv
`timescale 1ns/1ns
`include "jtag_slave_cfg.svh"

module word_fifo #(
    parameter int DEPTH_LOG2 = 3
) (
    input  logic                    clk,
    input  logic                    jtag_rstn_sync,
    input  logic                    flush,
    input  logic                    push,
    input  logic [`JTAG_DATA_W-1:0] push_data,
    input  logic                    pop,
    output logic [`JTAG_DATA_W-1:0] head,
    output logic                    not_empty,
    output logic                    full
);

    logic [`JTAG_DATA_W-1:0] mem [2**DEPTH_LOG2];
    logic [DEPTH_LOG2:0]     wr_ptr, rd_ptr;       // extra wrap bit

    assign not_empty = (wr_ptr != rd_ptr);
    assign full      = (wr_ptr == {~rd_ptr[DEPTH_LOG2], rd_ptr[DEPTH_LOG2-1:0]});
    assign head      = mem[rd_ptr[DEPTH_LOG2-1:0]];

    always_ff @(posedge clk or negedge jtag_rstn_sync) begin
        if (!jtag_rstn_sync) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else if (flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (push && !full)
                wr_ptr <= wr_ptr + 1'b1;
            if (pop && not_empty)
                rd_ptr <= rd_ptr + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (push && !full)
            mem[wr_ptr[DEPTH_LOG2-1:0]] <= push_data;
    end

    a_no_overflow: assert property (@(posedge clk) disable iff (!jtag_rstn_sync)
        push |-> !full)
        else $error("FIFO push while full");

endmodule

// File: design/jtag_slave_pkg.sv
package jtag_slave_pkg;

`include "jtag_slave_cfg.svh"

    typedef struct packed {
        logic [`JTAG_ID_W-1:0]   id;
        logic [`JTAG_DATA_W-1:0] addr;
        logic [`JTAG_LEN_W-1:0]  len;
        logic [1:0]              burst;
    } bus_addr_t;

    typedef struct packed {
        logic [`JTAG_DATA_W-1:0] data;
        logic [3:0]              strb;
        logic                    last;
    } bus_wdata_t;

    typedef struct packed {
        logic [`JTAG_ID_W-1:0] id;
        logic [1:0]            resp;
    } bus_bresp_t;

    typedef struct packed {
        logic [`JTAG_ID_W-1:0]   id;
        logic [`JTAG_DATA_W-1:0] data;
        logic [1:0]              resp;
        logic                    last;
    } bus_rdata_t;

    typedef enum logic [1:0] {RESP_OKAY = 2'd0, RESP_SLVERR = 2'd2} resp_e;
    typedef enum logic [1:0] {BURST_FIXED = 2'd0, BURST_INCR = 2'd1} burst_e;
    typedef enum logic [3:0] {OP_SHIFT = 4'd1, OP_TMS_HIGH = 4'd2} opcode_e;

    typedef struct packed {
        logic [3:0]  opcode;
        logic [27:0] cycle_num;
    } shift_cmd_t;

    // flush, empty, full per FIFO; done at bit 24
    typedef struct packed {
        logic [6:0] rsvd_31_25;
        logic       done;
        logic [4:0] rsvd_23_19;
        logic       cmd_full;
        logic       cmd_empty;
        logic       cmd_flush;
        logic [4:0] rsvd_15_11;
        logic       data_full;
        logic       data_empty;
        logic       data_flush;
        logic [4:0] rsvd_7_3;
        logic       out_full;
        logic       out_empty;
        logic       out_flush;
    } status_word_t;

    typedef union packed {
        status_word_t status;
        shift_cmd_t   cmd;
    } jtag_word_u;

endpackage

// File: include/jtag_slave_cfg.svh
`ifndef JTAG_SLAVE_CFG_SVH
`define JTAG_SLAVE_CFG_SVH

// bus widths
`define JTAG_DATA_W           32
`define JTAG_ID_W             4
`define JTAG_LEN_W            8

`define JTAG_BASE_ADDR        32'h1000_0000

// register map, word offsets from the base address
`define JTAG_REG_STATUS       32'd0
`define JTAG_REG_SHIFT_OUT    32'd1
`define JTAG_REG_SHIFT_IN     32'd2
`define JTAG_REG_SHIFT_CMD    32'd3

`define JTAG_FIFO_DEPTH_LOG2  3

// clocks per tck half period
`define JTAG_TCK_HALF         1
`define JTAG_MAX_SHIFT        32

`endif
